/* hdl/conv2_settings.svh */
`ifndef CONV2_SETTINGS_SVH
`define CONV2_SETTINGS_SVH

// feature map geometry
`define CONV2_ROW_PIXELS  12 // pixels per row
`define CONV2_CHANNELS    4  // input channels
`define CONV2_FMAP_ROWS   16 // rows per map
`define CONV2_NUM_KERNELS 8  // kernels per frame

// datapath widths
`define CONV2_PIX_W       8  // pixel / weight width
`define CONV2_PSUM_W      22 // partial sum, holds 36 taps of 255 x -128

// activation
`define CONV2_ACT_SHIFT   6  // right shift before saturation

// memory addressing
`define CONV2_ADDR_W      4  // one address per row

`endif

/* hdl/conv2_data_pkg.sv */
`include "conv2_settings.svh"

package conv2_data_pkg;

  // unsigned pixel from the previous layer
  typedef logic [`CONV2_PIX_W-1:0] pixel_t;

  // signed filter tap
  typedef logic signed [`CONV2_PIX_W-1:0] weight_t;

  // signed accumulator, one per output lane
  typedef logic signed [`CONV2_PSUM_W-1:0] psum_t;

  // one channel row, pixel x in byte x
  typedef pixel_t [`CONV2_ROW_PIXELS-1:0] pix_row_t;

  // the same row across all channels
  typedef pix_row_t [`CONV2_CHANNELS-1:0] chan_rows_t;

  // one filter row, byte (column*channels + channel)
  typedef weight_t [3*`CONV2_CHANNELS-1:0] filt_row_t;

  // one row of partial sums
  typedef psum_t [`CONV2_ROW_PIXELS-1:0] psum_row_t;

endpackage

/* hdl/conv2_ctrl_pkg.sv */
`include "conv2_settings.svh"

package conv2_ctrl_pkg;

  // controller phase
  typedef enum logic {
    IDLE,   // loading rows from the host
    REPLAY  // replaying the map once per kernel
  } ctrl_phase_t;

  // row address into the line memories
  typedef logic [`CONV2_ADDR_W-1:0] row_addr_t;

  // current kernel pass
  typedef logic [$clog2(`CONV2_NUM_KERNELS)-1:0] kernel_idx_t;

endpackage

/* hdl/conv2_row_if.sv */
`timescale 1ns/10ps

interface conv2_row_if;

  conv2_data_pkg::chan_rows_t rows;      // memory read data, all channels
  logic                       row_valid; // rows carry a slot of the pass
  logic                       row_pad;   // slot is a border row, use zeros
  logic                       row_first; // first slot of a kernel pass

  // controller side drives the strobes only
  modport src (
    output row_valid,
    output row_pad,
    output row_first
  );

  modport dst (
    input rows,
    input row_valid,
    input row_pad,
    input row_first
  );

endinterface

/* hdl/conv2_line_sram.sv */
`timescale 1ns/10ps
`include "conv2_settings.svh"

module conv2_line_sram (
  input  logic                      clk,
  input  logic                      en,
  input  logic                      we,
  input  conv2_ctrl_pkg::row_addr_t addr,
  input  conv2_data_pkg::pix_row_t  din,
  output conv2_data_pkg::pix_row_t  dout
);
  import conv2_data_pkg::*;

  pix_row_t mem [`CONV2_FMAP_ROWS]; // one entry per map row

  // single port, write has priority over read
  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        mem[addr] <= din;
      end else begin
        dout <= mem[addr]; // data valid the cycle after the address
      end
    end
  end

endmodule

/* hdl/conv2_row_ctrl.sv */
`timescale 1ns/10ps
`include "conv2_settings.svh"

module conv2_row_ctrl (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        en,
  input  logic                        din_valid,
  input  logic                        frame_end,
  output conv2_ctrl_pkg::row_addr_t   addr,
  output logic                        we,
  output conv2_ctrl_pkg::kernel_idx_t kernel_idx,
  output logic                        busy,
  conv2_row_if.src                    row_bus
);
  import conv2_ctrl_pkg::*;

  // slots 0 and LAST_SLOT are the zero rows above and below the map
  localparam int LAST_SLOT = `CONV2_FMAP_ROWS + 1;
  localparam int SLOT_W = $clog2(LAST_SLOT + 1);
  localparam kernel_idx_t LAST_KERNEL = kernel_idx_t'(`CONV2_NUM_KERNELS - 1);

  ctrl_phase_t       phase;
  row_addr_t         wr_ptr;
  logic [SLOT_W-1:0] slot;
  logic              pass_done;
  logic              issue_pad;
  logic              issue_first;

  assign busy = (phase == REPLAY);

  // host writes only land while idle
  assign we = (phase == IDLE) && din_valid;

  assign pass_done = (slot == SLOT_W'(LAST_SLOT));
  assign issue_first = busy && (slot == '0);
  assign issue_pad = busy && ((slot == '0) || pass_done);

  // slot s reads row s-1, pad slots read a don't-care row
  assign addr = busy ? row_addr_t'(slot - 1'b1) : wr_ptr;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase      <= IDLE;
      wr_ptr     <= '0;
      slot       <= '0;
      kernel_idx <= '0;
    end else if (en) begin
      case (phase)
        IDLE: begin
          if (frame_end) begin
            phase      <= REPLAY;
            wr_ptr     <= '0; // next map loads from row 0
            slot       <= '0;
            kernel_idx <= '0;
          end else if (din_valid) begin
            wr_ptr <= wr_ptr + 1'b1;
          end
        end
        REPLAY: begin
          if (pass_done) begin
            slot <= '0;
            if (kernel_idx == LAST_KERNEL) begin
              phase <= IDLE; // kernel_idx holds until next frame
            end else begin
              kernel_idx <= kernel_idx + 1'b1;
            end
          end else begin
            slot <= slot + 1'b1;
          end
        end
        default: begin
          phase <= IDLE;
        end
      endcase
    end
  end

  // strobes lag the address by one cycle, same as the memory read
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      row_bus.row_valid <= 1'b0;
      row_bus.row_pad   <= 1'b0;
      row_bus.row_first <= 1'b0;
    end else if (en) begin
      row_bus.row_valid <= busy;
      row_bus.row_pad   <= issue_pad;
      row_bus.row_first <= issue_first;
    end
  end

endmodule

/* hdl/conv2_window_mac.sv */
`timescale 1ns/10ps
`include "conv2_settings.svh"

module conv2_window_mac (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       en,
  conv2_row_if.dst                   row_bus,
  input  conv2_data_pkg::filt_row_t  filt_in_0,
  input  conv2_data_pkg::filt_row_t  filt_in_1,
  input  conv2_data_pkg::filt_row_t  filt_in_2,
  output conv2_data_pkg::psum_row_t  psum_row,
  output logic                       psum_valid
);
  import conv2_data_pkg::*;

  localparam int TAPS = 3;                      // 3x3 window
  localparam int PAD_W = `CONV2_ROW_PIXELS + 2; // one zero column each side

  typedef pixel_t [PAD_W-1:0] pad_row_t;
  typedef pad_row_t [`CONV2_CHANNELS-1:0] pad_chan_t;

  pad_chan_t win_new;       // incoming row, padded
  pad_chan_t win_mid;
  pad_chan_t win_old;       // oldest row, meets filter row 0
  filt_row_t filt_q [TAPS];
  logic [1:0] fill_cnt;     // rows seen this pass, saturates at 2
  logic       sum_en;
  psum_row_t  sums;

  // widen the incoming row with zero borders, whole row zero on pad slots
  always_comb begin
    win_new = '0;
    if (!row_bus.row_pad) begin
      for (int ch = 0; ch < `CONV2_CHANNELS; ch++) begin
        for (int x = 0; x < `CONV2_ROW_PIXELS; x++) begin
          win_new[ch][x+1] = row_bus.rows[ch][x];
        end
      end
    end
  end

  // two stored rows plus the live one, so sums register as the third row lands
  always_comb begin
    psum_t acc;
    for (int x = 0; x < `CONV2_ROW_PIXELS; x++) begin
      acc = '0;
      for (int c = 0; c < TAPS; c++) begin
        for (int ch = 0; ch < `CONV2_CHANNELS; ch++) begin
          acc = acc + $signed({1'b0, win_old[ch][x+c]}) *
                      $signed(filt_q[0][c*`CONV2_CHANNELS+ch]);
          acc = acc + $signed({1'b0, win_mid[ch][x+c]}) *
                      $signed(filt_q[1][c*`CONV2_CHANNELS+ch]);
          acc = acc + $signed({1'b0, win_new[ch][x+c]}) *
                      $signed(filt_q[2][c*`CONV2_CHANNELS+ch]);
        end
      end
      sums[x] = acc;
    end
  end

  assign sum_en = row_bus.row_valid && !row_bus.row_first && (fill_cnt == 2'd2);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fill_cnt   <= '0;
      psum_valid <= 1'b0;
    end else if (en) begin
      psum_valid <= sum_en;
      if (row_bus.row_first) begin
        fill_cnt <= 2'd1; // first row of the pass already counted
      end else if (row_bus.row_valid && fill_cnt != 2'd2) begin
        fill_cnt <= fill_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      if (row_bus.row_valid) begin
        win_old <= win_mid;
        win_mid <= win_new;
      end
      if (row_bus.row_first) begin
        filt_q[0] <= filt_in_0; // new kernel
        filt_q[1] <= filt_in_1;
        filt_q[2] <= filt_in_2;
      end
      if (sum_en) begin
        psum_row <= sums;
      end
    end
  end

endmodule

/* hdl/conv2_activation.sv */
`timescale 1ns/10ps
`include "conv2_settings.svh"

module conv2_activation (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      en,
  input  logic                      psum_valid,
  input  conv2_data_pkg::psum_row_t psum_row,
  output conv2_data_pkg::pix_row_t  out_row,
  output logic                      out_valid
);
  import conv2_data_pkg::*;

  pix_row_t act;

  // relu, shift, clamp to 8 bits
  always_comb begin
    psum_t shifted;
    for (int x = 0; x < `CONV2_ROW_PIXELS; x++) begin
      shifted = psum_row[x] >> `CONV2_ACT_SHIFT;
      if (psum_row[x][`CONV2_PSUM_W-1]) begin
        act[x] = '0; // negative sum
      end else if (|shifted[`CONV2_PSUM_W-1:`CONV2_PIX_W]) begin
        act[x] = '1; // saturate at 255
      end else begin
        act[x] = pixel_t'(shifted);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (en) begin
      out_valid <= psum_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (en && psum_valid) begin
      out_row <= act;
    end
  end

endmodule

/* hdl/top_convlayer2.sv */
`timescale 1ns/10ps

module top_convlayer2 (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        en,
  input  logic        din_valid,
  input  logic        frame_end,
  input  logic [95:0] data_in_0,
  input  logic [95:0] data_in_1,
  input  logic [95:0] data_in_2,
  input  logic [95:0] data_in_3,
  input  logic [95:0] filt_in_0,
  input  logic [95:0] filt_in_1,
  input  logic [95:0] filt_in_2,
  output logic [95:0] out_row,
  output logic        out_valid,
  output logic [2:0]  kernel_idx,
  output logic        busy
);
  import conv2_data_pkg::*;
  import conv2_ctrl_pkg::*;

  row_addr_t sram_addr; // shared by all channel memories
  logic      sram_we;
  psum_row_t psum_row;
  logic      psum_valid;

  conv2_row_if row_bus ();

  // one line memory per input channel
  conv2_line_sram i_sram_0 (
    .clk  (clk),
    .en   (en),
    .we   (sram_we),
    .addr (sram_addr),
    .din  (data_in_0),
    .dout (row_bus.rows[0])
  );

  conv2_line_sram i_sram_1 (
    .clk  (clk),
    .en   (en),
    .we   (sram_we),
    .addr (sram_addr),
    .din  (data_in_1),
    .dout (row_bus.rows[1])
  );

  conv2_line_sram i_sram_2 (
    .clk  (clk),
    .en   (en),
    .we   (sram_we),
    .addr (sram_addr),
    .din  (data_in_2),
    .dout (row_bus.rows[2])
  );

  conv2_line_sram i_sram_3 (
    .clk  (clk),
    .en   (en),
    .we   (sram_we),
    .addr (sram_addr),
    .din  (data_in_3),
    .dout (row_bus.rows[3])
  );

  conv2_row_ctrl i_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .en         (en),
    .din_valid  (din_valid),
    .frame_end  (frame_end),
    .addr       (sram_addr),
    .we         (sram_we),
    .kernel_idx (kernel_idx),
    .busy       (busy),
    .row_bus    (row_bus.src)
  );

  conv2_window_mac i_mac (
    .clk        (clk),
    .rst_n      (rst_n),
    .en         (en),
    .row_bus    (row_bus.dst),
    .filt_in_0  (filt_in_0),
    .filt_in_1  (filt_in_1),
    .filt_in_2  (filt_in_2),
    .psum_row   (psum_row),
    .psum_valid (psum_valid)
  );

  conv2_activation i_act (
    .clk        (clk),
    .rst_n      (rst_n),
    .en         (en),
    .psum_valid (psum_valid),
    .psum_row   (psum_row),
    .out_row    (out_row),
    .out_valid  (out_valid)
  );

endmodule

/* verification/tb_top_convlayer2.sv */
`timescale 1ns/10ps
`include "conv2_settings.svh"

module tb_top_convlayer2;

  localparam int NPIX = `CONV2_ROW_PIXELS;
  localparam int NCH = `CONV2_CHANNELS;
  localparam int NROWS = `CONV2_FMAP_ROWS;
  localparam int NKER = `CONV2_NUM_KERNELS;
  localparam int PASS_SLOTS = NROWS + 2; // pad, 16 rows, pad
  localparam int OUT_LAT = 5;           // slot issue to out_row
  localparam int WAIT_LIMIT = 2000;

  localparam logic [1:0] MAP_RANDOM = 2'd0;
  localparam logic [1:0] MAP_FULL = 2'd1;
  localparam logic [1:0] MAP_ZERO = 2'd2;
  localparam logic [1:0] MAP_CHECKER = 2'd3;
  localparam logic [1:0] FILT_RANDOM = 2'd0;
  localparam logic [1:0] FILT_MAX = 2'd1;
  localparam logic [1:0] FILT_MIXED = 2'd2;

  typedef struct packed {
    logic [1:0] map_kind;
    logic [1:0] filt_kind;
    logic       en_random;  // en low on random cycles
    logic       busy_noise; // din_valid / frame_end pulses while busy
    logic [7:0] exp_rows;   // output rows per frame
  } stim_entry_t;

  logic        clk;
  logic        rst_n;
  logic        en;
  logic        din_valid;
  logic        frame_end;
  logic [95:0] data_in_0;
  logic [95:0] data_in_1;
  logic [95:0] data_in_2;
  logic [95:0] data_in_3;
  logic [95:0] filt_in_0;
  logic [95:0] filt_in_1;
  logic [95:0] filt_in_2;
  logic [95:0] out_row;
  logic        out_valid;
  logic [2:0]  kernel_idx;
  logic        busy;

  stim_entry_t stim_table [4];
  logic [7:0]  fmap [NCH][NROWS][NPIX];
  logic [7:0]  wts [NKER][3][3][NCH]; // kernel, filter row, column, channel
  integer      seed;
  int          value_errs;
  int          timing_errs;
  int          other_errs;
  bit          timed_out;

  top_convlayer2 i_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .en         (en),
    .din_valid  (din_valid),
    .frame_end  (frame_end),
    .data_in_0  (data_in_0),
    .data_in_1  (data_in_1),
    .data_in_2  (data_in_2),
    .data_in_3  (data_in_3),
    .filt_in_0  (filt_in_0),
    .filt_in_1  (filt_in_1),
    .filt_in_2  (filt_in_2),
    .out_row    (out_row),
    .out_valid  (out_valid),
    .kernel_idx (kernel_idx),
    .busy       (busy)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  function automatic logic [95:0] map_row(input int ch, input int y);
    logic [95:0] row;
    for (int x = 0; x < NPIX; x++) begin
      row[x*8 +: 8] = fmap[ch][y][x];
    end
    return row;
  endfunction

  function automatic logic [95:0] filt_row(input int k, input int ky);
    logic [95:0] row;
    for (int kx = 0; kx < 3; kx++) begin
      for (int ch = 0; ch < NCH; ch++) begin
        row[(kx*NCH + ch)*8 +: 8] = wts[k][ky][kx][ch];
      end
    end
    return row;
  endfunction

  // 3x3x4 window with zero border, then relu, shift and clamp
  function automatic logic [7:0] expect_pixel(input int k, input int y, input int x);
    int acc;
    int py;
    int px;
    int v;
    acc = 0;
    for (int ky = 0; ky < 3; ky++) begin
      for (int kx = 0; kx < 3; kx++) begin
        for (int ch = 0; ch < NCH; ch++) begin
          py = y + ky - 1;
          px = x + kx - 1;
          if (py >= 0 && py < NROWS && px >= 0 && px < NPIX) begin
            acc = acc + int'(fmap[ch][py][px]) * int'($signed(wts[k][ky][kx][ch]));
          end
        end
      end
    end
    if (acc < 0) begin
      v = 0;
    end else begin
      v = acc >>> `CONV2_ACT_SHIFT;
    end
    if (v > 255) begin
      v = 255;
    end
    return 8'(v);
  endfunction

  function automatic logic [95:0] expect_row(input int k, input int y);
    logic [95:0] row;
    for (int x = 0; x < NPIX; x++) begin
      row[x*8 +: 8] = expect_pixel(k, y, x);
    end
    return row;
  endfunction

  task automatic build_map(input logic [1:0] kind);
    for (int ch = 0; ch < NCH; ch++) begin
      for (int y = 0; y < NROWS; y++) begin
        for (int x = 0; x < NPIX; x++) begin
          case (kind)
            MAP_RANDOM: fmap[ch][y][x] = 8'($random(seed));
            MAP_FULL:   fmap[ch][y][x] = 8'hff;
            MAP_ZERO:   fmap[ch][y][x] = 8'h00;
            default:    fmap[ch][y][x] = ((x + y + ch) % 2 == 1) ? 8'hff : 8'h00;
          endcase
        end
      end
    end
  endtask

  task automatic build_filters(input logic [1:0] kind);
    logic [7:0] mag;
    for (int k = 0; k < NKER; k++) begin
      for (int ky = 0; ky < 3; ky++) begin
        for (int kx = 0; kx < 3; kx++) begin
          for (int ch = 0; ch < NCH; ch++) begin
            mag = 8'($random(seed)) & 8'h7f;
            case (kind)
              FILT_RANDOM: wts[k][ky][kx][ch] = 8'($random(seed));
              FILT_MAX:    wts[k][ky][kx][ch] = 8'd127;
              default:     wts[k][ky][kx][ch] = ((k + ky + kx + ch) % 2 == 1) ? mag : 8'd0 - mag;
            endcase
          end
        end
      end
    end
  endtask

  // host follows kernel_idx
  task automatic drive_filters();
    filt_in_0 = filt_row(int'(kernel_idx), 0);
    filt_in_1 = filt_row(int'(kernel_idx), 1);
    filt_in_2 = filt_row(int'(kernel_idx), 2);
  endtask

  task automatic scramble_data_in();
    data_in_0 = {$random(seed), $random(seed), $random(seed)};
    data_in_1 = {$random(seed), $random(seed), $random(seed)};
    data_in_2 = {$random(seed), $random(seed), $random(seed)};
    data_in_3 = {$random(seed), $random(seed), $random(seed)};
  endtask

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    while (busy !== 1'b0 && cycles < WAIT_LIMIT) begin
      @(posedge clk);
      #0.5;
      en = 1'b1;
      cycles++;
    end
    if (busy !== 1'b0) begin
      $display("timeout: busy did not fall before loading the next map");
      other_errs++;
      timed_out = 1'b1;
    end
  endtask

  task automatic load_map();
    for (int y = 0; y < NROWS; y++) begin
      @(posedge clk);
      #0.5;
      en = 1'b1;
      din_valid = 1'b1;
      data_in_0 = map_row(0, y);
      data_in_1 = map_row(1, y);
      data_in_2 = map_row(2, y);
      data_in_3 = map_row(3, y);
    end
    @(posedge clk);
    #0.5;
    din_valid = 1'b0;
  endtask

  // frame_end cycle is active cycle 0, so slot 0 of pass 0 is active cycle 1
  task automatic run_frame(input stim_entry_t ent);
    int act;
    int n_out;
    int cycles;
    int k;
    int r;
    int exp_act;
    logic [95:0] exp_row;
    logic [2:0]  exp_kidx;
    logic        exp_busy;
    act = 0;
    n_out = 0;
    cycles = 0;
    @(posedge clk);
    #0.5;
    en = 1'b1;
    frame_end = 1'b1;
    drive_filters();
    while (n_out < int'(ent.exp_rows) && cycles < WAIT_LIMIT) begin
      @(posedge clk);
      #0.5;
      frame_end = 1'b0;
      din_valid = 1'b0;
      en = !(ent.en_random && (($random(seed) & 3) == 0));
      if (ent.busy_noise && busy) begin
        din_valid = 1'($random(seed));
        frame_end = 1'($random(seed));
        scramble_data_in();
      end
      drive_filters();
      @(negedge clk);
      cycles++;
      if (en) begin
        act++;
        // high from slot 0 of kernel 0 through slot 17 of the last kernel
        exp_busy = (act <= NKER * PASS_SLOTS);
        if (busy !== exp_busy) begin
          $display("mismatch busy active cycle %0d: got %h, expected %h",
                   act, busy, exp_busy);
          timing_errs++;
        end
        if (out_valid === 1'b1) begin
          k = n_out / NROWS;
          r = n_out % NROWS;
          exp_act = 1 + PASS_SLOTS * k + r + OUT_LAT;
          // kernel_idx steps at the next pass start, before the last rows leave
          exp_kidx = (r + OUT_LAT >= PASS_SLOTS && k < NKER - 1) ? 3'(k + 1) : 3'(k);
          exp_row = expect_row(k, r);
          if (act != exp_act) begin
            $display("mismatch out_valid kernel %0d row %0d: active cycle %h, expected %h",
                     k, r, act, exp_act);
            timing_errs++;
          end
          if (out_row !== exp_row) begin
            $display("mismatch out_row kernel %0d row %0d: got %h, expected %h",
                     k, r, out_row, exp_row);
            value_errs++;
          end
          if (kernel_idx !== exp_kidx) begin
            $display("mismatch kernel_idx kernel %0d row %0d: got %h, expected %h",
                     k, r, kernel_idx, exp_kidx);
            value_errs++;
          end
          n_out++;
        end
      end
    end
    if (n_out < int'(ent.exp_rows)) begin
      $display("timeout: only %0d of %0d output rows arrived", n_out, ent.exp_rows);
      other_errs++;
      timed_out = 1'b1;
    end
  endtask

  // no rows beyond the expected count, controller back in idle
  task automatic drain_check();
    int extra;
    extra = 0;
    for (int i = 0; i < 2 * PASS_SLOTS; i++) begin
      @(posedge clk);
      #0.5;
      en = 1'b1;
      din_valid = 1'b0;
      frame_end = 1'b0;
      @(negedge clk);
      if (out_valid !== 1'b0) begin
        extra++;
      end
    end
    if (extra != 0) begin
      $display("out_valid stayed active for %0d cycles after the last row of the frame", extra);
      other_errs++;
    end
    if (busy !== 1'b0) begin
      $display("busy still high after the frame finished");
      other_errs++;
    end
  endtask

  initial begin
    seed = 32'h63c2fbe1;
    value_errs = 0;
    timing_errs = 0;
    other_errs = 0;
    timed_out = 1'b0;
    rst_n = 1'b0;
    en = 1'b0;
    din_valid = 1'b0;
    frame_end = 1'b0;
    data_in_0 = '0;
    data_in_1 = '0;
    data_in_2 = '0;
    data_in_3 = '0;
    filt_in_0 = '0;
    filt_in_1 = '0;
    filt_in_2 = '0;

    stim_table[0] = '{MAP_RANDOM, FILT_RANDOM, 1'b0, 1'b0, 8'd128};
    stim_table[1] = '{MAP_FULL, FILT_MAX, 1'b1, 1'b1, 8'd128};    // saturation
    stim_table[2] = '{MAP_CHECKER, FILT_MIXED, 1'b1, 1'b1, 8'd128}; // relu on negatives
    stim_table[3] = '{MAP_ZERO, FILT_MIXED, 1'b0, 1'b1, 8'd128};

    repeat (8) @(posedge clk);
    #0.5;
    rst_n = 1'b1;
    en = 1'b1;
    @(negedge clk);
    if (out_valid !== 1'b0 || busy !== 1'b0 || kernel_idx !== 3'd0) begin
      $display("mismatch after reset: out_valid %h busy %h kernel_idx %h, expected 0 0 0",
               out_valid, busy, kernel_idx);
      value_errs++;
    end

    for (int i = 0; i < 4; i++) begin
      if (!timed_out) begin
        build_map(stim_table[i].map_kind);
        build_filters(stim_table[i].filt_kind);
        wait_idle();
        load_map();
        run_frame(stim_table[i]);
        drain_check();
      end
    end

    $display("errors: value %0d, timing %0d, other %0d", value_errs, timing_errs, other_errs);
    if (value_errs + timing_errs + other_errs == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+hdl
hdl/conv2_data_pkg.sv
hdl/conv2_ctrl_pkg.sv
hdl/conv2_row_if.sv
hdl/conv2_line_sram.sv
hdl/conv2_row_ctrl.sv
hdl/conv2_window_mac.sv
hdl/conv2_activation.sv
hdl/top_convlayer2.sv
verification/tb_top_convlayer2.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps -Wno-fatal -f vlog.f \
  --top-module tb_top_convlayer2 -Mdir obj_dir -o sim_tb > sim.log 2>&1 \
  && ./obj_dir/sim_tb >> sim.log 2>&1 \
  || echo "TESTBENCH FAILED" >> sim.log

grep -q "TESTBENCH FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log || { echo "no result in sim.log"; exit 1; }
echo "simulation passed"
